//--- dcache_checker.sv
// Data cache checker comparing acked read data and memory burst counts with expected values.

`timescale 1ns/1ps

module dcache_checker (
    input  logic              clk,
    input  logic              arst,

    // Observed DUT signals.
    input  logic              i_ack,
    input  dcache_pkg::word_t i_rdata,
    input  logic              i_mem_req,
    input  logic              i_mem_we,
    input  logic              i_mem_ack,

    // Expected response of the current test.
    input  string             i_name,
    input  logic              i_check_read,
    input  dcache_pkg::word_t i_exp_rdata,
    input  int                i_exp_fills,
    input  int                i_exp_wbs,

    output int                o_errors,
    output int                o_checks
);

    int   rd_words;
    int   wr_words;
    int   errors;
    int   checks;
    logic ack_q;

    assign o_errors = errors;
    assign o_checks = checks;

    // Whole bursts only, a leftover word means a broken burst.
    task automatic check_bursts(input string kind, input int words, input int expected);
        int bursts;
        bursts = words / dcache_pkg::WORDS_PER_BLOCK;
        if (words % dcache_pkg::WORDS_PER_BLOCK != 0) begin
            $display("Test %s saw a partial %s burst of %0d words", i_name, kind, words);
            errors++;
        end
        if (bursts != expected) begin
            $display("Error %s: %s bursts expected %0d actual %0d",
                     i_name, kind, expected, bursts);
            errors++;
        end
    endtask

    // ------------------------------------------------------------
    // Word counting and compare at the rising ack.
    // ------------------------------------------------------------
    always @(posedge clk, posedge arst) begin
        if (arst) begin
            rd_words = 0;
            wr_words = 0;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= i_ack;
            // One sampled req and ack pair per word.
            if (i_mem_req && i_mem_ack) begin
                if (i_mem_we) begin
                    wr_words++;
                end else begin
                    rd_words++;
                end
            end
            if (i_ack && !ack_q) begin
                checks++;
                if (i_check_read && (i_rdata !== i_exp_rdata)) begin
                    $display("Error %s: read data expected %h actual %h",
                             i_name, i_exp_rdata, i_rdata);
                    errors++;
                end
                check_bursts("fill", rd_words, i_exp_fills);
                check_bursts("write-back", wr_words, i_exp_wbs);
                rd_words = 0;
                wr_words = 0;
            end
        end
    end

endmodule

//--- dcache_data_array.sv
// Data cache block store with word reads, processor word writes and whole-block fills.

`timescale 1ns/1ps

module dcache_data_array (
    input  logic                                          clk,
    input  dcache_pkg::index_t                            i_index,
    input  dcache_pkg::way_t                              i_way,
    input  logic [$clog2(dcache_pkg::WORDS_PER_BLOCK)-1:0] i_word_sel,
    input  dcache_pkg::word_t                             i_wdata,
    input  logic                                          i_word_write_en,
    input  logic                                          i_block_fill_en,
    input  dcache_pkg::block_t                            i_fill_block,
    output dcache_pkg::word_t                             o_rdata,
    output dcache_pkg::block_t                            o_victim_block
);

    // One entry per set and way.
    dcache_pkg::block_t blocks_q [dcache_pkg::SETS*dcache_pkg::WAYS];

    logic [$bits(dcache_pkg::index_t)+$bits(dcache_pkg::way_t)-1:0] slot;

    assign slot = {i_index, i_way};

    assign o_victim_block = blocks_q[slot];
    assign o_rdata        = blocks_q[slot][i_word_sel*dcache_pkg::DATA_W +: dcache_pkg::DATA_W];

    // A fill replaces the whole block.
    always_ff @(posedge clk) begin
        if (i_block_fill_en) begin
            blocks_q[slot] <= i_fill_block;
        end else if (i_word_write_en) begin
            blocks_q[slot][i_word_sel*dcache_pkg::DATA_W +: dcache_pkg::DATA_W] <= i_wdata;
        end
    end

endmodule

//--- dcache_fsm.sv
// Data cache controller FSM sequencing lookup, write-back, allocate and the processor ack.

`timescale 1ns/1ps

module dcache_fsm (
    input  logic clk,
    input  logic arst,

    // Processor request and array status.
    input  logic i_req,
    input  logic i_we,
    input  logic i_hit,
    input  logic i_dirty,
    input  logic i_r_last,
    input  logic i_b_resp,

    // Ack and update strobes.
    output logic o_ack,
    output logic o_lookup,
    output logic o_lru_update,
    output logic o_valid_update,
    output logic o_block_fill_en,
    output logic o_word_write_en,
    output logic o_start_read,
    output logic o_start_write,
    output logic o_addr_control
);

    dcache_pkg::cache_state_t state_q;
    dcache_pkg::cache_state_t state_d;

    always_ff @(posedge clk, posedge arst) begin
        if (arst) begin
            state_q <= dcache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Ack rises one cycle into RESPOND and falls with the request.
    always_ff @(posedge clk, posedge arst) begin
        if (arst) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= (state_q == dcache_pkg::RESPOND) && i_req;
        end
    end

    // ------------------------------------------------------------
    // Next state.
    // ------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::IDLE: begin
                if (i_req && !o_ack) begin
                    state_d = dcache_pkg::COMPARE_TAG;
                end
            end
            dcache_pkg::COMPARE_TAG: begin
                if (i_hit) begin
                    state_d = dcache_pkg::RESPOND;
                end else if (i_dirty) begin
                    state_d = dcache_pkg::WRITE_BACK;
                end else begin
                    state_d = dcache_pkg::ALLOCATE;
                end
            end
            dcache_pkg::WRITE_BACK: begin
                if (i_b_resp) begin
                    state_d = dcache_pkg::ALLOCATE;
                end
            end
            dcache_pkg::ALLOCATE: begin
                if (i_r_last) begin
                    state_d = dcache_pkg::COMPARE_TAG;
                end
            end
            dcache_pkg::RESPOND: begin
                if (!i_req) begin
                    state_d = dcache_pkg::IDLE;
                end
            end
            default: state_d = dcache_pkg::IDLE;
        endcase
    end

    // ------------------------------------------------------------
    // Strobes.
    // ------------------------------------------------------------
    always_comb begin
        o_lookup        = 1'b0;
        o_lru_update    = 1'b0;
        o_valid_update  = 1'b0;
        o_block_fill_en = 1'b0;
        o_word_write_en = 1'b0;
        o_start_read    = 1'b0;
        o_start_write   = 1'b0;
        o_addr_control  = 1'b0;
        case (state_q)
            dcache_pkg::COMPARE_TAG: begin
                o_lookup = 1'b1;
                if (i_hit) begin
                    o_lru_update    = 1'b1;
                    o_word_write_en = i_we;
                end else if (i_dirty) begin
                    // Victim goes out first.
                    o_addr_control = 1'b1;
                    o_start_write  = 1'b1;
                end else begin
                    o_start_read = 1'b1;
                end
            end
            dcache_pkg::WRITE_BACK: begin
                o_start_read = i_b_resp;
            end
            dcache_pkg::ALLOCATE: begin
                o_block_fill_en = i_r_last;
                o_valid_update  = i_r_last;
            end
            default: begin
                o_lookup = 1'b0;
            end
        endcase
    end

endmodule

//--- dcache_mem_port.sv
// Memory burst engine moving one cache block as four four-phase word exchanges.

`timescale 1ns/1ps

module dcache_mem_port (
    input  logic               clk,
    input  logic               arst,
    input  logic               i_start_read,
    input  logic               i_start_write,
    input  dcache_pkg::addr_t  i_base_addr,
    input  dcache_pkg::block_t i_wblock,
    input  logic               i_mem_ack,
    input  dcache_pkg::word_t  i_mem_rdata,
    output logic               o_r_last,
    output logic               o_b_resp,
    output dcache_pkg::block_t o_fill_block,
    output logic               o_mem_req,
    output logic               o_mem_we,
    output dcache_pkg::addr_t  o_mem_addr,
    output dcache_pkg::word_t  o_mem_wdata
);

    typedef enum logic [1:0] {
        MP_IDLE,
        MP_REQ,
        MP_ACK_LOW
    } mp_state_t;

    mp_state_t                                               state_q;
    logic [$clog2(dcache_pkg::WORDS_PER_BLOCK)-1:0]          beat_q;
    logic [dcache_pkg::ADDR_W-dcache_pkg::OFFSET_W-1:0]      blk_q;
    dcache_pkg::block_t                                      wblock_q;

    // Word address within the block, ascending.
    assign o_mem_addr  = {blk_q, beat_q, {(dcache_pkg::OFFSET_W-$bits(beat_q)){1'b0}}};
    assign o_mem_wdata = wblock_q[beat_q*dcache_pkg::DATA_W +: dcache_pkg::DATA_W];

    always_ff @(posedge clk, posedge arst) begin
        if (arst) begin
            state_q   <= MP_IDLE;
            beat_q    <= '0;
            o_mem_req <= 1'b0;
            o_mem_we  <= 1'b0;
            o_r_last  <= 1'b0;
            o_b_resp  <= 1'b0;
        end else begin
            o_r_last <= 1'b0;
            o_b_resp <= 1'b0;
            case (state_q)
                MP_IDLE: begin
                    if (i_start_read || i_start_write) begin
                        beat_q    <= '0;
                        o_mem_we  <= i_start_write;
                        o_mem_req <= 1'b1;
                        state_q   <= MP_REQ;
                    end
                end
                MP_REQ: begin
                    if (i_mem_ack) begin
                        o_mem_req <= 1'b0;
                        state_q   <= MP_ACK_LOW;
                    end
                end
                MP_ACK_LOW: begin
                    // Next word only once memory has released ack.
                    if (!i_mem_ack) begin
                        if (beat_q == '1) begin
                            o_r_last <= !o_mem_we;
                            o_b_resp <= o_mem_we;
                            state_q  <= MP_IDLE;
                        end else begin
                            beat_q    <= beat_q + 1'b1;
                            o_mem_req <= 1'b1;
                            state_q   <= MP_REQ;
                        end
                    end
                end
                default: state_q <= MP_IDLE;
            endcase
        end
    end

    // Burst payload.
    always_ff @(posedge clk) begin
        if (state_q == MP_IDLE && (i_start_read || i_start_write)) begin
            blk_q    <= i_base_addr[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W];
            wblock_q <= i_wblock;
        end
        if (state_q == MP_REQ && i_mem_ack && !o_mem_we) begin
            o_fill_block <= {i_mem_rdata, o_fill_block[$bits(o_fill_block)-1:dcache_pkg::DATA_W]};
        end
    end

endmodule

//--- dcache_pkg.sv
// Data cache package with cache geometry, field types and the controller state encoding.

package dcache_pkg;

    // ------------------------------------------------------------
    // Geometry.
    // ------------------------------------------------------------
    localparam int WAYS            = 4;
    localparam int SETS            = 16;
    localparam int WORDS_PER_BLOCK = 4;
    localparam int ADDR_W          = 32;
    localparam int DATA_W          = 32;

    // Address split is tag, index, then byte offset.
    localparam int OFFSET_W        = 4;
    localparam int INDEX_W         = 4;
    localparam int TAG_W           = ADDR_W - INDEX_W - OFFSET_W;

    // ------------------------------------------------------------
    // Field types.
    // ------------------------------------------------------------
    typedef logic [ADDR_W-1:0]                 addr_t;
    typedef logic [DATA_W-1:0]                 word_t;
    typedef logic [TAG_W-1:0]                  tag_t;
    typedef logic [INDEX_W-1:0]                index_t;
    typedef logic [$clog2(WAYS)-1:0]           way_t;
    typedef logic [WORDS_PER_BLOCK*DATA_W-1:0] block_t;

    // Controller states.
    typedef enum logic [2:0] {
        IDLE        = 3'd0,
        COMPARE_TAG = 3'd1,
        WRITE_BACK  = 3'd2,
        ALLOCATE    = 3'd3,
        RESPOND     = 3'd4
    } cache_state_t;

endpackage

//--- dcache_tag_array.sv
// Data cache tag store with valid, dirty and tree pseudo-LRU state, hit and victim selection.

`timescale 1ns/1ps

module dcache_tag_array (
    input  logic                clk,
    input  logic                arst,
    input  logic                i_lookup,
    input  dcache_pkg::index_t  i_index,
    input  dcache_pkg::tag_t    i_tag,
    input  logic                i_lru_update,
    input  logic                i_valid_update,
    input  logic                i_set_dirty,
    input  logic                i_clear_dirty,
    output logic                o_hit,
    output dcache_pkg::way_t    o_hit_way,
    output dcache_pkg::way_t    o_victim_way,
    output logic                o_victim_dirty,
    output dcache_pkg::tag_t    o_victim_tag
);

    dcache_pkg::tag_t               tags_q  [dcache_pkg::SETS][dcache_pkg::WAYS];
    logic [dcache_pkg::WAYS-1:0]    valid_q [dcache_pkg::SETS];
    logic [dcache_pkg::WAYS-1:0]    dirty_q [dcache_pkg::SETS];
    logic [dcache_pkg::WAYS-2:0]    lru_q   [dcache_pkg::SETS];

    logic [dcache_pkg::WAYS-1:0]    match;
    logic                           found_invalid;
    logic [dcache_pkg::WAYS-2:0]    lru_cur;
    logic [dcache_pkg::WAYS-2:0]    lru_next;
    dcache_pkg::way_t               hit_way;
    dcache_pkg::way_t               victim_way;

    // ------------------------------------------------------------
    // Compare all ways and pick a victim.
    // ------------------------------------------------------------
    always_comb begin
        hit_way       = '0;
        victim_way    = '0;
        found_invalid = 1'b0;
        lru_cur       = lru_q[i_index];
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            match[w] = valid_q[i_index][w] && (tags_q[i_index][w] == i_tag);
            if (match[w]) begin
                hit_way = dcache_pkg::way_t'(w);
            end
        end
        // Lowest invalid way first, else follow the tree.
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            if (!valid_q[i_index][w] && !found_invalid) begin
                victim_way    = dcache_pkg::way_t'(w);
                found_invalid = 1'b1;
            end
        end
        if (!found_invalid) begin
            victim_way = lru_cur[0] ? {1'b1, lru_cur[2]} : {1'b0, lru_cur[1]};
        end
    end

    // Point the tree away from the way just used.
    always_comb begin
        lru_next    = lru_cur;
        lru_next[0] = ~hit_way[1];
        if (hit_way[1]) begin
            lru_next[2] = ~hit_way[0];
        end else begin
            lru_next[1] = ~hit_way[0];
        end
    end

    assign o_hit          = i_lookup && |match;
    assign o_hit_way      = hit_way;
    assign o_victim_way   = victim_way;
    assign o_victim_dirty = valid_q[i_index][victim_way] && dirty_q[i_index][victim_way];
    assign o_victim_tag   = tags_q[i_index][victim_way];

    // ------------------------------------------------------------
    // State update.
    // ------------------------------------------------------------
    always_ff @(posedge clk, posedge arst) begin
        if (arst) begin
            for (int s = 0; s < dcache_pkg::SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                lru_q[s]   <= '0;
            end
        end else begin
            if (i_valid_update) begin
                valid_q[i_index][victim_way] <= 1'b1;
            end
            if (i_clear_dirty) begin
                dirty_q[i_index][victim_way] <= 1'b0;
            end
            if (i_set_dirty) begin
                dirty_q[i_index][hit_way] <= 1'b1;
            end
            if (i_lru_update) begin
                lru_q[i_index] <= lru_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid_update) begin
            tags_q[i_index][victim_way] <= i_tag;
        end
    end

endmodule

//--- dcache_tb.sv
// Data cache testbench with clock, reset, memory model, file-driven stimulus and watchdog.

`timescale 1ns/1ps

module dcache_tb;

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 4;
    localparam int CYCLES_PER_TEST = 200;
    localparam int MEM_WORDS       = 256;

    logic              clk;
    logic              arst;
    logic              i_req;
    logic              i_we;
    dcache_pkg::addr_t i_addr;
    dcache_pkg::word_t i_wdata;
    logic              o_ack;
    dcache_pkg::word_t o_rdata;
    logic              i_mem_ack;
    dcache_pkg::word_t i_mem_rdata;
    logic              o_mem_req;
    logic              o_mem_we;
    dcache_pkg::addr_t o_mem_addr;
    dcache_pkg::word_t o_mem_wdata;

    // Test table.
    string             t_name [$];
    string             t_op   [$];
    dcache_pkg::addr_t t_addr [$];
    dcache_pkg::word_t t_wdata[$];
    dcache_pkg::word_t t_rdata[$];
    int                t_fills[$];
    int                t_wbs  [$];
    int                n_tests;
    bit                loaded;

    // Expected response of the request in flight.
    string             cur_name;
    logic              cur_read;
    dcache_pkg::word_t cur_rdata;
    int                cur_fills;
    int                cur_wbs;

    int                errors;
    int                checks;
    int                tb_errors;

    // Backing memory, each slot remembers the word address it holds.
    dcache_pkg::word_t mem_word[MEM_WORDS];
    logic [29:0]       mem_tag [MEM_WORDS];

    dcache_top uut (
        .clk(clk), .arst(arst), .i_req(i_req), .i_we(i_we), .i_addr(i_addr),
        .i_wdata(i_wdata), .o_ack(o_ack), .o_rdata(o_rdata),
        .i_mem_ack(i_mem_ack), .i_mem_rdata(i_mem_rdata), .o_mem_req(o_mem_req),
        .o_mem_we(o_mem_we), .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata)
    );

    dcache_checker u_check (
        .clk(clk), .arst(arst), .i_ack(o_ack), .i_rdata(o_rdata),
        .i_mem_req(o_mem_req), .i_mem_we(o_mem_we), .i_mem_ack(i_mem_ack),
        .i_name(cur_name), .i_check_read(cur_read), .i_exp_rdata(cur_rdata),
        .i_exp_fills(cur_fills), .i_exp_wbs(cur_wbs),
        .o_errors(errors), .o_checks(checks)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------
    // Memory model.
    // ------------------------------------------------------------
    function automatic dcache_pkg::word_t read_word(input logic [29:0] wa);
        logic [7:0] slot;
        slot = wa[7:0];
        if (mem_tag[slot] == wa) begin
            return mem_word[slot];
        end
        // Never written, so the fill rule still holds.
        return {2'b00, wa} ^ 32'h5a5a0000;
    endfunction

    function automatic void write_word(input logic [29:0] wa, input dcache_pkg::word_t data);
        logic [7:0] slot;
        slot = wa[7:0];
        mem_tag[slot]  = wa;
        mem_word[slot] = data;
    endfunction

    initial begin : memory_model
        int          delay;
        logic [29:0] wa;
        i_mem_ack   = 1'b0;
        i_mem_rdata = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_tag[i]  = 30'(i);
            mem_word[i] = 32'(i) ^ 32'h5a5a0000;
        end
        forever begin
            @(posedge clk);
            if (o_mem_req && !i_mem_ack) begin
                delay = 1 + int'($urandom % 3);
                repeat (delay - 1) @(posedge clk);
                wa = o_mem_addr[31:2];
                if (o_mem_we) begin
                    write_word(wa, o_mem_wdata);
                end else begin
                    i_mem_rdata <= read_word(wa);
                end
                i_mem_ack <= 1'b1;
                do @(posedge clk); while (o_mem_req);
                i_mem_ack <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus.
    // ------------------------------------------------------------
    task automatic load_tests();
        int                fd;
        int                n;
        int                fills;
        int                wbs;
        string             line;
        string             name;
        string             op;
        dcache_pkg::addr_t addr;
        dcache_pkg::word_t wdata;
        dcache_pkg::word_t rdata;
        fd = $fopen("dcache_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file dcache_tests.txt");
            tb_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %s %h %h %h %d %d", name, op, addr, wdata, rdata,
                            fills, wbs);
                if (n == 7) begin
                    t_name.push_back(name);
                    t_op.push_back(op);
                    t_addr.push_back(addr);
                    t_wdata.push_back(wdata);
                    t_rdata.push_back(rdata);
                    t_fills.push_back(fills);
                    t_wbs.push_back(wbs);
                end
            end
        end
        $fclose(fd);
        n_tests = t_name.size();
    endtask

    task automatic apply_reset();
        @(posedge clk);
        arst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        arst <= 1'b0;
    endtask

    // Full four-phase handshake for one request.
    task automatic do_access(input int k);
        @(posedge clk);
        cur_name  <= t_name[k];
        cur_read  <= (t_op[k] == "R");
        cur_rdata <= t_rdata[k];
        cur_fills <= t_fills[k];
        cur_wbs   <= t_wbs[k];
        i_req     <= 1'b1;
        i_we      <= (t_op[k] == "W");
        i_addr    <= t_addr[k];
        i_wdata   <= t_wdata[k];
        do @(posedge clk); while (!o_ack);
        i_req <= 1'b0;
        do @(posedge clk); while (o_ack);
    endtask

    initial begin : main
        int n_access;
        void'($urandom(32'hc089e69b));
        arst      = 1'b1;
        i_req     = 1'b0;
        i_we      = 1'b0;
        i_addr    = '0;
        i_wdata   = '0;
        cur_name  = "none";
        cur_read  = 1'b0;
        cur_rdata = '0;
        cur_fills = 0;
        cur_wbs   = 0;
        n_access  = 0;
        load_tests();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        arst <= 1'b0;
        for (int k = 0; k < n_tests; k++) begin
            if (t_op[k] == "X") begin
                apply_reset();
            end else begin
                do_access(k);
                n_access++;
            end
        end
        repeat (2) @(posedge clk);
        if (n_tests == 0) begin
            $display("No tests were loaded from the test file");
            tb_errors++;
        end
        if (checks != n_access) begin
            $display("Checker compared %0d responses but %0d requests were sent",
                     checks, n_access);
            tb_errors++;
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, checks,
                 errors + tb_errors);
        if (errors == 0 && tb_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog scaled to the number of tests.
    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = (n_tests > 0 ? n_tests : 1) * CYCLES_PER_TEST;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- dcache_tests.txt
# Columns: name, op (R read, W write, X reset), byte address (hex), write data (hex),
#          expected read data (hex), expected fill bursts, expected write-back bursts.
rd_miss_set1        R 00000010 00000000 5a5a0004 1 0
rd_hit_word0        R 00000010 00000000 5a5a0004 0 0
rd_hit_word2        R 00000018 00000000 5a5a0006 0 0
rd_hit_word3        R 0000001c 00000000 5a5a0007 0 0
wr_hit_word1        W 00000014 cafe0001 00000000 0 0
rd_after_write      R 00000014 00000000 cafe0001 0 0
rd_miss_tag1        R 00000110 00000000 5a5a0044 1 0
rd_miss_tag2        R 00000214 00000000 5a5a0085 1 0
rd_miss_tag3        R 0000031c 00000000 5a5a00c7 1 0
rd_evict_dirty_tag0 R 00000418 00000000 5a5a0106 1 1
wr_hit_tag3         W 00000310 beef0330 00000000 0 0
rd_refill_tag0      R 00000014 00000000 cafe0001 1 0
rd_refill_tag0_w2   R 00000018 00000000 5a5a0006 0 0
rd_hit_tag2         R 00000210 00000000 5a5a0084 0 0
rd_hit_tag4         R 0000041c 00000000 5a5a0107 0 0
rd_evict_dirty_tag3 R 00000118 00000000 5a5a0046 1 1
rd_refill_tag3      R 00000310 00000000 beef0330 1 0
reset_mid           X 00000000 00000000 00000000 0 0
rd_miss_after_rst   R 00000310 00000000 beef0330 1 0
rd_hit_after_rst    R 0000031c 00000000 5a5a00c7 0 0
wr_miss_set2        W 00000024 12345678 00000000 1 0
rd_hit_written      R 00000024 00000000 12345678 0 0
rd_hit_set2_w0      R 00000020 00000000 5a5a0008 0 0
rd_miss_set5        R 0000005c 00000000 5a5a0017 1 0
rd_hit_set5_w1      R 00000054 00000000 5a5a0015 0 0

//--- dcache_top.f
dcache_pkg.sv
dcache_fsm.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_mem_port.sv
dcache_top.sv
dcache_checker.sv
dcache_tb.sv

//--- dcache_top.sv
// Data cache top joining controller, tag and data stores and the memory burst engine.

`timescale 1ns/1ps

module dcache_top (
    input  logic               clk,
    input  logic               arst,

    // Processor port.
    input  logic               i_req,
    input  logic               i_we,
    input  dcache_pkg::addr_t  i_addr,
    input  dcache_pkg::word_t  i_wdata,
    output logic               o_ack,
    output dcache_pkg::word_t  o_rdata,

    // Memory port.
    input  logic               i_mem_ack,
    input  dcache_pkg::word_t  i_mem_rdata,
    output logic               o_mem_req,
    output logic               o_mem_we,
    output dcache_pkg::addr_t  o_mem_addr,
    output dcache_pkg::word_t  o_mem_wdata
);

    dcache_pkg::tag_t    req_tag;
    dcache_pkg::index_t  req_index;
    logic [$clog2(dcache_pkg::WORDS_PER_BLOCK)-1:0] word_sel;

    logic                lookup, lru_update, valid_update, block_fill_en, word_write_en;
    logic                start_read, start_write, addr_control;
    logic                hit, victim_dirty, r_last, b_resp;
    dcache_pkg::way_t    hit_way, victim_way, way_sel;
    dcache_pkg::tag_t    victim_tag;
    dcache_pkg::addr_t   base_addr;
    dcache_pkg::word_t   array_rdata;
    dcache_pkg::block_t  victim_block, fill_block;

    // ------------------------------------------------------------
    // Address fields and selects.
    // ------------------------------------------------------------
    assign req_tag   = i_addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
    assign req_index = i_addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
    assign word_sel  = i_addr[dcache_pkg::OFFSET_W-1 -: $bits(word_sel)];

    // Victim block address for write-back, request block address for fill.
    assign base_addr = addr_control ? {victim_tag, req_index, {dcache_pkg::OFFSET_W{1'b0}}}
                                    : {req_tag, req_index, {dcache_pkg::OFFSET_W{1'b0}}};
    assign way_sel   = hit ? hit_way : victim_way;

    // Read word held for the whole ack phase.
    always_ff @(posedge clk) begin
        if (lru_update) begin
            o_rdata <= array_rdata;
        end
    end

    dcache_fsm u_fsm (
        .clk(clk), .arst(arst), .i_req(i_req), .i_we(i_we), .i_hit(hit),
        .i_dirty(victim_dirty), .i_r_last(r_last), .i_b_resp(b_resp),
        .o_ack(o_ack), .o_lookup(lookup), .o_lru_update(lru_update),
        .o_valid_update(valid_update), .o_block_fill_en(block_fill_en),
        .o_word_write_en(word_write_en), .o_start_read(start_read),
        .o_start_write(start_write), .o_addr_control(addr_control)
    );

    dcache_tag_array u_tags (
        .clk(clk), .arst(arst), .i_lookup(lookup), .i_index(req_index), .i_tag(req_tag),
        .i_lru_update(lru_update), .i_valid_update(valid_update),
        .i_set_dirty(word_write_en), .i_clear_dirty(valid_update),
        .o_hit(hit), .o_hit_way(hit_way), .o_victim_way(victim_way),
        .o_victim_dirty(victim_dirty), .o_victim_tag(victim_tag)
    );

    dcache_data_array u_data (
        .clk(clk), .i_index(req_index), .i_way(way_sel), .i_word_sel(word_sel),
        .i_wdata(i_wdata), .i_word_write_en(word_write_en),
        .i_block_fill_en(block_fill_en), .i_fill_block(fill_block),
        .o_rdata(array_rdata), .o_victim_block(victim_block)
    );

    dcache_mem_port u_mem (
        .clk(clk), .arst(arst), .i_start_read(start_read), .i_start_write(start_write),
        .i_base_addr(base_addr), .i_wblock(victim_block), .i_mem_ack(i_mem_ack),
        .i_mem_rdata(i_mem_rdata), .o_r_last(r_last), .o_b_resp(b_resp),
        .o_fill_block(fill_block), .o_mem_req(o_mem_req), .o_mem_we(o_mem_we),
        .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the data cache testbench with Verilator, run it and look for the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module dcache_tb -f dcache_top.f -o Vdcache_tb \
    || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vdcache_tb)"
echo "$sim_out"

echo "$sim_out" | grep -qF '*** PASSED ***' && exit 0 || exit 1
